// File: Bender.yml
package:
  name: tart_lite

sources:
  - logic/tart_pkg.sv
  - logic/tart_regs.sv
  - logic/tart_block_fsm.sv
  - logic/tart_block_counter.sv
  - logic/tart_correlator.sv
  - logic/tart_lite.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_tart_lite.sv

// File: bench/tb_clock.sv
module tb_clock (
   output logic b_clk,
   output logic rst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 10;

   initial begin
      b_clk = 1'b0;
      forever #2 b_clk = ~b_clk;      // 4 ns period
   end

   // Release just after an edge, clear of the sampling point
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge b_clk);
      #1 rst_n_o = 1'b1;
   end

endmodule

// File: bench/tb_tart_lite.sv
module tb_tart_lite;
   timeunit 1ns;
   timeprecision 1ps;

   // ----------------------------------------
   // Test constants
   // ----------------------------------------
   localparam int BLOCK_LOG2   = 3;
   localparam int BLOCK_LEN    = 1 << BLOCK_LOG2;
   localparam int BLOCK_CYCLES = BLOCK_LEN + 1;          // Samples plus handover
   localparam int MAX_ACCESSES = 155;                    // Two cycles each
   localparam int MAX_BLOCKS   = 20;
   localparam int TIMEOUT_CYCLES =
      4 * (10 + 2 * MAX_ACCESSES + BLOCK_CYCLES * MAX_BLOCKS);  // Margin of four

   localparam logic [6:0] ADR_CONTROL = {tart_pkg::CTL_REGION, tart_pkg::CTL_REG_CONTROL};
   localparam logic [6:0] ADR_STATUS  = {tart_pkg::CTL_REGION, tart_pkg::CTL_REG_STATUS};
   localparam logic [6:0] ADR_RESET   = {tart_pkg::CTL_REGION, tart_pkg::CTL_REG_RESET};

   localparam logic [7:0] CTRL_RUN = 8'h31;  // Enable, block log2 3
   localparam logic [7:0] CTRL_OVW = 8'h33;  // Same plus overwrite
   localparam logic [7:0] ST_AVAIL = 8'h01;
   localparam logic [7:0] ST_OVF   = 8'h02;
   localparam logic [7:0] ST_FULL  = 8'h04;

   logic       b_clk;
   logic       rst_n;
   logic       b_stb;
   logic       b_we;
   logic [6:0] b_adr;
   logic [7:0] b_dat_w;
   logic [3:0] ax_data;
   logic       b_ack;
   logic [7:0] b_dat_r;

   logic       check_on;   // Current read is compared
   logic [7:0] exp_data;
   logic [7:0] exp_mask;
   string      check_name;
   logic [7:0] lfsr_q;
   logic       split_pat;  // Antenna 3 inverted
   int         cycle_cnt = 0;

   tb_clock clock_inst (
      .b_clk   (b_clk),
      .rst_n_o (rst_n)
   );

   tart_lite tart_lite_inst (
      .b_clk     (b_clk),
      .rst_n_i   (rst_n),
      .b_stb_i   (b_stb),
      .b_we_i    (b_we),
      .b_adr_i   (b_adr),
      .b_dat_i   (b_dat_w),
      .ax_data_i (ax_data),
      .b_ack_o   (b_ack),
      .b_dat_o   (b_dat_r)
   );

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {1'b0, s[7:1]} ^ (s[0] ? 8'hb8 : 8'h00);  // x^8+x^6+x^5+x^4+1
   endfunction

   // Pair count from the pattern rule, a taken as 0
   function automatic logic [7:0] expected_vis(input logic split, input int i, input int j);
      logic bit_i;
      logic bit_j;
      bit_i = split && (i == 3);
      bit_j = split && (j == 3);
      return (bit_i == bit_j) ? 8'(BLOCK_LEN) : 8'h00;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] exp);
      fail_run($sformatf("CHECK FAILED at time %0t: %s = 0x%02h, expected 0x%02h",
                         $time, name, got, exp));
   endtask

   // Strobe, then one cycle for the ack to show
   task automatic bus_access(input logic we, input logic [6:0] adr, input logic [7:0] wdat,
                             input logic chk, input string name, input logic [7:0] exp,
                             input logic [7:0] mask, output logic [7:0] rdat);
      b_stb      = 1'b1;
      b_we       = we;
      b_adr      = adr;
      b_dat_w    = wdat;
      check_on   = chk;
      check_name = name;
      exp_mask   = mask;
      exp_data   = exp & mask;
      @(posedge b_clk);
      #1;
      b_stb   = 1'b0;
      b_we    = 1'b0;
      b_dat_w = 8'h00;
      rdat    = b_dat_r;                 // Ack cycle
      @(posedge b_clk);
      #1;
   endtask

   task automatic bus_write(input logic [6:0] adr, input logic [7:0] dat);
      logic [7:0] rd;
      bus_access(1'b1, adr, dat, 1'b1, "b_dat_o (write)", 8'h00, 8'hff, rd);
   endtask

   task automatic check_read(input logic [6:0] adr, input string name,
                             input logic [7:0] exp, input logic [7:0] mask);
      logic [7:0] rd;
      bus_access(1'b0, adr, 8'h00, 1'b1, name, exp, mask, rd);
   endtask

   task automatic poll_status(input logic [7:0] mask);
      logic [7:0] rd;
      do begin
         bus_access(1'b0, ADR_STATUS, 8'h00, 1'b0, "", 8'h00, 8'h00, rd);
      end while ((rd & mask) == 8'h00);
   endtask

   // Registers 0 to 5 in pair order, last read frees the bank
   task automatic check_bank(input logic split);
      int p;
      p = 0;
      for (int i = 0; i < 3; i++) begin
         for (int j = i + 1; j < 4; j++) begin
            check_read(7'(p), $sformatf("b_dat_o (pair %0d,%0d)", i, j),
                       expected_vis(split, i, j), 8'hff);
            p++;
         end
      end
   endtask

   // ----------------------------------------
   // Antennas, one LFSR step per cycle
   // ----------------------------------------
   always @(posedge b_clk) begin
      #1;
      lfsr_q  = lfsr_step(lfsr_q);
      ax_data = split_pat ? {~lfsr_q[0], {3{lfsr_q[0]}}} : {4{lfsr_q[0]}};
   end

   always @(posedge b_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("Timeout: test did not finish in %0d cycles", TIMEOUT_CYCLES));
      end
   end

   // Checking
   a_read_data : assert property (@(posedge b_clk) disable iff (!rst_n)
      check_on && b_ack |-> ((b_dat_r & exp_mask) == exp_data))
      else report_mismatch(check_name, $sampled(b_dat_r) & exp_mask, exp_data);
   a_ack_next : assert property (@(posedge b_clk) disable iff (!rst_n)
      b_stb |=> b_ack)
      else fail_run("Bus error: no ack on the cycle after a strobe");
   a_ack_single : assert property (@(posedge b_clk) disable iff (!rst_n)
      !b_stb |=> !b_ack)
      else fail_run("Bus error: ack without a strobe on the cycle before");

   initial begin
      b_stb      = 1'b0;
      b_we       = 1'b0;
      b_adr      = 7'h00;
      b_dat_w    = 8'h00;
      ax_data    = 4'h0;
      lfsr_q     = 8'd63;                // Seed
      split_pat  = 1'b1;
      check_on   = 1'b0;
      exp_data   = 8'h00;
      exp_mask   = 8'h00;
      check_name = "";
      @(posedge rst_n);
      @(posedge b_clk);
      #1;

      // Reset state and unmapped reads
      check_read(ADR_CONTROL, "b_dat_o (control)", 8'h00, 8'hff);
      check_read(ADR_STATUS, "b_dat_o (status)", 8'h00, 8'hff);
      check_read(7'h00, "b_dat_o (pair 0,1)", 8'h00, 8'hff);
      check_read(7'h06, "b_dat_o (unmapped 0x06)", 8'h00, 8'hff);
      check_read(7'h10, "b_dat_o (unmapped 0x10)", 8'h00, 8'hff);
      check_read(7'h45, "b_dat_o (unmapped 0x45)", 8'h00, 8'hff);
      check_read(7'h7a, "b_dat_o (unmapped 0x7a)", 8'h00, 8'hff);

      // Control readback, enable kept off
      bus_write(ADR_CONTROL, 8'ha6);
      check_read(ADR_CONTROL, "b_dat_o (control)", 8'ha6, 8'hff);
      bus_write(ADR_CONTROL, 8'h5a);
      check_read(ADR_CONTROL, "b_dat_o (control)", 8'h5a, 8'hff);

      // First bank, split pattern
      bus_write(ADR_CONTROL, CTRL_RUN);
      poll_status(ST_AVAIL);
      check_bank(1'b1);
      check_read(ADR_STATUS, "b_dat_o (status)", 8'h00, ST_AVAIL | ST_FULL);

      // ----------------------------------------
      // Overflow with overwrite off
      // ----------------------------------------
      poll_status(ST_AVAIL);             // Clean split bank
      split_pat = 1'b0;
      poll_status(ST_FULL);
      check_read(ADR_STATUS, "b_dat_o (status)", ST_AVAIL | ST_OVF | ST_FULL, 8'hff);
      check_bank(1'b1);                  // Dropped blocks left it alone
      check_read(ADR_STATUS, "b_dat_o (status)", ST_OVF, 8'hff);
      poll_status(ST_AVAIL);
      check_bank(1'b0);

      // Overwrite mode starts with overflow clear
      bus_write(ADR_RESET, 8'h01);
      bus_write(ADR_CONTROL, CTRL_OVW);
      poll_status(ST_AVAIL);             // Equal bank in place
      split_pat = 1'b1;
      repeat (6 * BLOCK_CYCLES) @(posedge b_clk);
      #1;
      check_bank(1'b1);
      check_read(ADR_STATUS, "b_dat_o (status)", ST_OVF, ST_OVF | ST_FULL);

      // Soft reset
      bus_write(ADR_RESET, 8'h01);
      check_read(ADR_CONTROL, "b_dat_o (control)", 8'h00, 8'hff);
      check_read(ADR_STATUS, "b_dat_o (status)", 8'h00, 8'hff);
      check_read(7'h00, "b_dat_o (pair 0,1)", 8'h00, 8'hff);

      repeat (2) @(posedge b_clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: logic/tart_block_counter.sv
module tart_block_counter (
   input  logic                                 b_clk,
   input  logic                                 rst_n_i,
   input  logic                                 aq_enable_i,
   input  logic                                 accum_en_i,
   input  logic [tart_pkg::BLOCK_LOG2_BITS-1:0] block_log2_i,
   input  logic                                 soft_clr_i,
   output logic                                 block_last_o
);

   logic [tart_pkg::BLOCK_CNT_BITS-1:0] cnt_q;
   logic [tart_pkg::BLOCK_CNT_BITS-1:0] last_cnt;  // Block length minus one

   // Log2 of 7 wraps to all ones, 127
   assign last_cnt = (tart_pkg::BLOCK_CNT_BITS'(1) << block_log2_i) - 1'b1;

   assign block_last_o = accum_en_i && (cnt_q == last_cnt);

   always_ff @(posedge b_clk) begin
      if (!rst_n_i || soft_clr_i) begin
         cnt_q <= '0;
      end else if (!aq_enable_i) begin
         cnt_q <= '0;                    // Restart the block on re-enable
      end else if (accum_en_i) begin
         if (block_last_o) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

// File: logic/tart_block_fsm.sv
module tart_block_fsm (
   input  logic b_clk,
   input  logic rst_n_i,
   input  logic aq_enable_i,
   input  logic overwrite_i,
   input  logic soft_clr_i,
   input  logic bank_read_i,
   input  logic block_last_i,
   output logic accum_en_o,
   output logic bank_load_o,
   output logic available_o,
   output logic overflow_o,
   output logic full_o
);

   tart_pkg::block_state_e state_q;
   logic                   bank_load_q;  // Handover cycle after a block
   logic                   available_q;
   logic                   overflow_q;
   logic                   bank_busy;    // Bank still unread after this cycle

   assign bank_busy = available_q && !bank_read_i;

   always_ff @(posedge b_clk) begin
      if (!rst_n_i || soft_clr_i) begin
         state_q     <= tart_pkg::IDLE;
         bank_load_q <= 1'b0;
         available_q <= 1'b0;
         overflow_q  <= 1'b0;
      end else begin
         bank_load_q <= 1'b0;
         if (bank_load_q) begin
            available_q <= 1'b1;    // New bank wins over a same-cycle read
         end else if (bank_read_i) begin
            available_q <= 1'b0;
         end
         case (state_q)
            tart_pkg::IDLE: if (aq_enable_i) state_q <= tart_pkg::ACCUM;
            tart_pkg::ACCUM: begin
               if (block_last_i) begin
                  if (bank_busy) overflow_q <= 1'b1;  // Sticky
                  if (!bank_busy || overwrite_i) begin
                     bank_load_q <= 1'b1;
                  end else begin
                     state_q <= tart_pkg::FULL;   // Block dropped
                  end
               end else if (!aq_enable_i) begin
                  state_q <= tart_pkg::IDLE;
               end
            end
            tart_pkg::FULL: begin
               if (bank_read_i) state_q <= aq_enable_i ? tart_pkg::ACCUM : tart_pkg::IDLE;
            end
            default: state_q <= tart_pkg::IDLE;
         endcase
      end
   end

   // No sampling in the handover cycle
   assign accum_en_o  = (state_q == tart_pkg::ACCUM) && aq_enable_i && !bank_load_q;
   assign bank_load_o = bank_load_q;
   assign available_o = available_q;
   assign overflow_o  = overflow_q;
   assign full_o      = state_q == tart_pkg::FULL;

   // Stall holds until the host drains the bank
   a_full_stalls : assert property (@(posedge b_clk) disable iff (!rst_n_i)
      $rose(full_o) |-> (!accum_en_o until (bank_read_i || soft_clr_i)));

endmodule

// File: logic/tart_correlator.sv
module tart_correlator (
   input  logic                              b_clk,
   input  logic                              rst_n_i,
   input  logic [tart_pkg::NUM_ANTENNA-1:0]  ax_data_i,
   input  logic                              accum_en_i,
   input  logic                              block_last_i,
   input  logic                              bank_load_i,
   input  logic                              soft_clr_i,
   input  logic [tart_pkg::VIS_SEL_BITS-1:0] vis_sel_i,
   output logic [tart_pkg::ACCUM_BITS-1:0]   vis_dat_o
);

   logic [tart_pkg::NUM_PAIRS-1:0]  match;      // Both bits of a pair agree
   logic [tart_pkg::ACCUM_BITS-1:0] acc_q  [tart_pkg::NUM_PAIRS];
   logic [tart_pkg::ACCUM_BITS-1:0] bank_q [tart_pkg::NUM_PAIRS];
   logic                            blk_end_q;  // Last sample was taken

   // ----------------------------------------
   // Pair map, (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   // ----------------------------------------
   for (genvar i = 0; i < tart_pkg::NUM_ANTENNA - 1; i++) begin : g_ant_a
      for (genvar j = i + 1; j < tart_pkg::NUM_ANTENNA; j++) begin : g_ant_b
         localparam int P = i * (2 * tart_pkg::NUM_ANTENNA - i - 1) / 2 + (j - i - 1);
         assign match[P] = ~(ax_data_i[i] ^ ax_data_i[j]);  // XNOR correlator
      end
   end

   // ----------------------------------------
   // Accumulators and bank
   // ----------------------------------------
   always_ff @(posedge b_clk) begin
      if (!rst_n_i || soft_clr_i) begin
         blk_end_q <= 1'b0;
         for (int p = 0; p < tart_pkg::NUM_PAIRS; p++) begin
            acc_q[p]  <= '0;
            bank_q[p] <= '0;
         end
      end else begin
         blk_end_q <= block_last_i;
         for (int p = 0; p < tart_pkg::NUM_PAIRS; p++) begin
            if (bank_load_i) begin
               bank_q[p] <= acc_q[p];      // Includes the last sample
            end
            if (blk_end_q) begin
               acc_q[p] <= '0;             // Loaded or dropped, restart
            end else if (accum_en_i && match[p]) begin
               acc_q[p] <= acc_q[p] + 1'b1;
            end
         end
      end
   end

   // Readback mux, indices 6 and 7 read 0
   always_comb begin
      vis_dat_o = '0;
      for (int p = 0; p < tart_pkg::NUM_PAIRS; p++) begin
         if (vis_sel_i == tart_pkg::VIS_SEL_BITS'(p)) begin
            vis_dat_o = bank_q[p];
         end
      end
   end

   // Loads only come in the handover cycle right after a block end
   a_load_after_end : assert property (@(posedge b_clk) disable iff (!rst_n_i)
      bank_load_i |-> blk_end_q);

endmodule

// File: logic/tart_lite.sv
module tart_lite (
   input  logic                             b_clk,
   input  logic                             rst_n_i,
   input  logic                             b_stb_i,
   input  logic                             b_we_i,
   input  logic [tart_pkg::ADR_BITS-1:0]    b_adr_i,
   input  logic [tart_pkg::BUS_BITS-1:0]    b_dat_i,
   input  logic [tart_pkg::NUM_ANTENNA-1:0] ax_data_i,
   output logic                             b_ack_o,
   output logic [tart_pkg::BUS_BITS-1:0]    b_dat_o
);

   // Register block controls
   logic                                 aq_enable;
   logic                                 overwrite;
   logic [tart_pkg::BLOCK_LOG2_BITS-1:0] block_log2;
   logic                                 soft_clr;
   logic                                 bank_read;
   logic [tart_pkg::VIS_SEL_BITS-1:0]    vis_sel;

   // Status and readback
   logic                                 available;
   logic                                 overflow;
   logic                                 full;
   logic [tart_pkg::ACCUM_BITS-1:0]      vis_dat;

   // Block sequencing
   logic                                 block_last;
   logic                                 accum_en;
   logic                                 bank_load;

   tart_regs regs_inst (
      .b_clk        (b_clk),
      .rst_n_i      (rst_n_i),
      .b_stb_i      (b_stb_i),
      .b_we_i       (b_we_i),
      .b_adr_i      (b_adr_i),
      .b_dat_i      (b_dat_i),
      .available_i  (available),
      .overflow_i   (overflow),
      .full_i       (full),
      .vis_dat_i    (vis_dat),
      .b_ack_o      (b_ack_o),
      .b_dat_o      (b_dat_o),
      .aq_enable_o  (aq_enable),
      .overwrite_o  (overwrite),
      .block_log2_o (block_log2),
      .soft_clr_o   (soft_clr),
      .bank_read_o  (bank_read),
      .vis_sel_o    (vis_sel)
   );

   tart_block_fsm fsm_inst (
      .b_clk        (b_clk),
      .rst_n_i      (rst_n_i),
      .aq_enable_i  (aq_enable),
      .overwrite_i  (overwrite),
      .soft_clr_i   (soft_clr),
      .bank_read_i  (bank_read),
      .block_last_i (block_last),
      .accum_en_o   (accum_en),
      .bank_load_o  (bank_load),
      .available_o  (available),
      .overflow_o   (overflow),
      .full_o       (full)
   );

   tart_block_counter counter_inst (
      .b_clk        (b_clk),
      .rst_n_i      (rst_n_i),
      .aq_enable_i  (aq_enable),
      .accum_en_i   (accum_en),
      .block_log2_i (block_log2),
      .soft_clr_i   (soft_clr),
      .block_last_o (block_last)
   );

   tart_correlator correlator_inst (
      .b_clk        (b_clk),
      .rst_n_i      (rst_n_i),
      .ax_data_i    (ax_data_i),
      .accum_en_i   (accum_en),
      .block_last_i (block_last),
      .bank_load_i  (bank_load),
      .soft_clr_i   (soft_clr),
      .vis_sel_i    (vis_sel),
      .vis_dat_o    (vis_dat)
   );

endmodule

// File: logic/tart_pkg.sv
package tart_pkg;

   // ----------------------------------------
   // Sizes
   // ----------------------------------------
   localparam int NUM_ANTENNA     = 4;
   localparam int NUM_PAIRS       = NUM_ANTENNA * (NUM_ANTENNA - 1) / 2;  // One per baseline
   localparam int BUS_BITS        = 8;
   localparam int ADR_BITS        = 7;
   localparam int ACCUM_BITS      = 8;                       // Holds a full 128-sample block
   localparam int BLOCK_LOG2_BITS = 3;
   localparam int BLOCK_CNT_BITS  = (1 << BLOCK_LOG2_BITS) - 1;  // Counts up to 127
   localparam int VIS_SEL_BITS    = 3;                       // Pair index on readback

   // ----------------------------------------
   // Address map
   // ----------------------------------------
   localparam logic [2:0] ACQ_REGION      = 3'h0;  // 0x00..0x0f, visibility bank
   localparam logic [3:0] CTL_REGION      = 4'hf;  // 0x78..0x7f, control block
   localparam logic [2:0] CTL_REG_CONTROL = 3'd0;
   localparam logic [2:0] CTL_REG_STATUS  = 3'd1;
   localparam logic [2:0] CTL_REG_RESET   = 3'd7;

   // Control register fields
   localparam int CTL_ENABLE_BIT    = 0;
   localparam int CTL_OVERWRITE_BIT = 1;
   localparam int CTL_LOG2_LSB      = 4;  // Block log2 in bits 6:4

   // Status register fields
   localparam int STAT_AVAIL_BIT    = 0;
   localparam int STAT_OVERFLOW_BIT = 1;
   localparam int STAT_FULL_BIT     = 2;

   // Same 7-bit address, split per region
   typedef union packed {
      struct packed {
         logic [2:0] region;
         logic [3:0] index;
      } acq;
      struct packed {
         logic [3:0] region;
         logic [2:0] index;
      } ctl;
   } bus_adr_u;

   typedef enum logic [1:0] {IDLE, ACCUM, FULL} block_state_e;

endpackage

// File: logic/tart_regs.sv
module tart_regs (
   input  logic                                  b_clk,
   input  logic                                  rst_n_i,
   input  logic                                  b_stb_i,
   input  logic                                  b_we_i,
   input  tart_pkg::bus_adr_u                    b_adr_i,
   input  logic [tart_pkg::BUS_BITS-1:0]         b_dat_i,
   input  logic                                  available_i,
   input  logic                                  overflow_i,
   input  logic                                  full_i,
   input  logic [tart_pkg::ACCUM_BITS-1:0]       vis_dat_i,
   output logic                                  b_ack_o,
   output logic [tart_pkg::BUS_BITS-1:0]         b_dat_o,
   output logic                                  aq_enable_o,
   output logic                                  overwrite_o,
   output logic [tart_pkg::BLOCK_LOG2_BITS-1:0]  block_log2_o,
   output logic                                  soft_clr_o,
   output logic                                  bank_read_o,
   output logic [tart_pkg::VIS_SEL_BITS-1:0]     vis_sel_o
);

   logic                          acq_hit;   // Address in the bank region
   logic                          ctl_hit;   // Address in the control region
   logic                          vis_hit;   // One of the six pair registers
   logic                          ctl_wr;
   logic [tart_pkg::BUS_BITS-1:0] ctrl_q;
   logic [tart_pkg::BUS_BITS-1:0] status;
   logic [tart_pkg::BUS_BITS-1:0] rd_data;

   // ----------------------------------------
   // Address decode, both views
   // ----------------------------------------
   assign acq_hit = b_adr_i.acq.region == tart_pkg::ACQ_REGION;
   assign ctl_hit = b_adr_i.ctl.region == tart_pkg::CTL_REGION;
   assign vis_hit = acq_hit && (b_adr_i.acq.index < tart_pkg::NUM_PAIRS);

   assign ctl_wr     = b_stb_i && b_we_i && ctl_hit &&
                       (b_adr_i.ctl.index == tart_pkg::CTL_REG_CONTROL);
   assign soft_clr_o = b_stb_i && b_we_i && ctl_hit &&
                       (b_adr_i.ctl.index == tart_pkg::CTL_REG_RESET);

   // Reading the last pair releases the bank
   assign bank_read_o = b_stb_i && !b_we_i && acq_hit &&
                        (b_adr_i.acq.index == 4'(tart_pkg::NUM_PAIRS - 1));

   assign vis_sel_o = b_adr_i.acq.index[tart_pkg::VIS_SEL_BITS-1:0];  // Bank mux, same cycle

   // Control fields
   assign aq_enable_o  = ctrl_q[tart_pkg::CTL_ENABLE_BIT];
   assign overwrite_o  = ctrl_q[tart_pkg::CTL_OVERWRITE_BIT];
   assign block_log2_o = ctrl_q[tart_pkg::CTL_LOG2_LSB +: tart_pkg::BLOCK_LOG2_BITS];

   always_comb begin
      status = '0;
      status[tart_pkg::STAT_AVAIL_BIT]    = available_i;
      status[tart_pkg::STAT_OVERFLOW_BIT] = overflow_i;
      status[tart_pkg::STAT_FULL_BIT]     = full_i;
   end

   // Read mux, unmapped reads give 0
   always_comb begin
      rd_data = '0;
      if (vis_hit) begin
         rd_data = vis_dat_i;
      end else if (ctl_hit) begin
         case (b_adr_i.ctl.index)
            tart_pkg::CTL_REG_CONTROL: rd_data = ctrl_q;
            tart_pkg::CTL_REG_STATUS:  rd_data = status;
            default:                   rd_data = '0;
         endcase
      end
   end

   // ----------------------------------------
   // Registers
   // ----------------------------------------
   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (soft_clr_o) begin
         ctrl_q <= '0;           // Soft reset also drops enable
      end else if (ctl_wr) begin
         ctrl_q <= b_dat_i;
      end
   end

   // Ack and data one cycle after the strobe
   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         b_ack_o <= 1'b0;
         b_dat_o <= '0;
      end else begin
         b_ack_o <= b_stb_i;
         b_dat_o <= (b_stb_i && !b_we_i) ? rd_data : '0;  // Writes return 0
      end
   end

   // No lost and no stray acks on a bus without back-pressure
   a_ack_follows_stb : assert property (@(posedge b_clk) disable iff (!rst_n_i)
      b_stb_i |=> b_ack_o);
   a_no_stray_ack : assert property (@(posedge b_clk) disable iff (!rst_n_i)
      !b_stb_i |=> !b_ack_o);

endmodule

// File: tart_lite.f
logic/tart_pkg.sv
logic/tart_regs.sv
logic/tart_block_fsm.sv
logic/tart_block_counter.sv
logic/tart_correlator.sv
logic/tart_lite.sv
bench/tb_clock.sv
bench/tb_tart_lite.sv
